/* Bender.yml */
package:
  name: cc_update

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/graph_pkg.sv
      - source/bus_pkg.sv
      - source/cu_update_config.sv
      - source/sync_fifo.sv
      - source/update_kernel_control.sv
      - source/cu_update_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_clock_gen.sv
      - tests/update_tb.sv

/* include/cc_update_defs.svh */
// widths are fixed for the whole unit; the FIFO almost-full level must leave room for about six records still in flight
`ifndef CC_UPDATE_DEFS_SVH
`define CC_UPDATE_DEFS_SVH

////////////////////////////////////////
// graph widths
////////////////////////////////////////

// vertex index, component value and finished-vertex count
`define CC_VERTEX_BITS 32

// edge counts and out-degree
`define CC_EDGE_BITS 32

// one identity coordinate
`define CC_ID_BITS 8

////////////////////////////////////////
// pending write queue
////////////////////////////////////////

`define CC_WRITE_FIFO_DEPTH 16
`define CC_WRITE_FIFO_ALFULL 8

`endif

/* project.f */
+incdir+include
source/graph_pkg.sv
source/bus_pkg.sv
source/cu_update_config.sv
source/sync_fifo.sv
source/update_kernel_control.sv
source/cu_update_top.sv
tests/tb_clock_gen.sv
tests/update_tb.sv

/* source/bus_pkg.sv */
// bus-side records only; the opcode encoding must match the downstream write buffer
`default_nettype none

`include "cc_update_defs.svh"

package bus_pkg;

	typedef struct packed {
		logic full;
		logic alfull;
		logic empty;
		logic valid;
	} buffer_status;

	// x in the upper half when packed
	typedef struct packed {
		logic [`CC_ID_BITS-1:0] x;
		logic [`CC_ID_BITS-1:0] y;
	} cu_identity;

	typedef struct packed {
		logic       valid;
		cu_identity identity;
	} write_response;

	typedef enum logic [1:0] {
		cmd_none            = 2'd0,
		cmd_write_component = 2'd1
	} write_opcode;

	typedef struct packed {
		write_opcode                opcode;
		logic [`CC_VERTEX_BITS-1:0] index;
		cu_identity                 identity;
		logic [`CC_VERTEX_BITS-1:0] data;
	} write_payload;

	typedef struct packed {
		logic         valid;
		write_payload payload;
	} write_command;

endpackage

`default_nettype wire

/* source/cu_update_config.sv */
// two write-only registers: address 0 bit 0 is enable, address 1 is the identity {x, y}; no readback
`timescale 1ns/1ps
`default_nettype none

`include "cc_update_defs.svh"

module cu_update_config (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       cfg_write,
	input  logic                       cfg_addr,
	input  logic [2*`CC_ID_BITS-1:0]   cfg_data,
	output logic                       enabled,
	output bus_pkg::cu_identity        identity
);

	////////////////////////////////////////
	// host register decode
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled  <= 1'b0;
			identity <= '0;
		end else if (cfg_write) begin
			if (cfg_addr == 1'b0) begin
				enabled <= cfg_data[0];
			end else begin
				// upper byte is x, lower byte is y
				identity <= bus_pkg::cu_identity'(cfg_data);
			end
		end
	end

endmodule

`default_nettype wire

/* source/cu_update_top.sv */
// one compute unit; identity and enable come only from the host port, nothing is read back
`timescale 1ns/1ps
`default_nettype none

`include "cc_update_defs.svh"

module cu_update_top (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        cfg_write,
	input  logic                        cfg_addr,
	input  logic [2*`CC_ID_BITS-1:0]    cfg_data,
	input  graph_pkg::vertex_job        vertex_job,
	input  graph_pkg::edge_record       edge_in,
	output logic                        edge_request,
	input  bus_pkg::buffer_status       data_status,
	input  bus_pkg::buffer_status       write_status,
	input  bus_pkg::write_response      write_resp,
	input  logic [`CC_EDGE_BITS-1:0]    continue_accum,
	output logic                        bus_request,
	input  logic                        bus_grant,
	output bus_pkg::write_command       write_out,
	output logic [`CC_VERTEX_BITS-1:0]  finished_vertices,
	output logic [`CC_EDGE_BITS-1:0]    write_count,
	output logic [`CC_EDGE_BITS-1:0]    edge_progress
);

	logic                enabled;
	bus_pkg::cu_identity identity;

	// host registers
	cu_update_config config_i (
		.clock    (clock),
		.rstn     (rstn),
		.cfg_write(cfg_write),
		.cfg_addr (cfg_addr),
		.cfg_data (cfg_data),
		.enabled  (enabled),
		.identity (identity)
	);

	// update datapath
	update_kernel_control kernel_i (
		.clock            (clock),
		.rstn             (rstn),
		.enabled_in       (enabled),
		.identity         (identity),
		.vertex_job       (vertex_job),
		.edge_in          (edge_in),
		.data_status      (data_status),
		.write_status     (write_status),
		.write_resp       (write_resp),
		.continue_accum   (continue_accum),
		.edge_request     (edge_request),
		.bus_request      (bus_request),
		.bus_grant        (bus_grant),
		.write_out        (write_out),
		.finished_vertices(finished_vertices),
		.write_count      (write_count),
		.edge_progress    (edge_progress)
	);

endmodule

`default_nettype wire

/* source/graph_pkg.sv */
// graph-side records only; every valid bit is a single-cycle-qualified level from the edge reader
`default_nettype none

`include "cc_update_defs.svh"

package graph_pkg;

	// current vertex under update
	typedef struct packed {
		logic [`CC_VERTEX_BITS-1:0] id;
		logic [`CC_EDGE_BITS-1:0]   out_degree;
	} vertex_payload;

	typedef struct packed {
		logic          valid;
		vertex_payload payload;
	} vertex_job;

	// one edge of the connected-components pass
	typedef struct packed {
		logic [`CC_VERTEX_BITS-1:0] comp_high;
		logic [`CC_VERTEX_BITS-1:0] comp_comp_high;
		logic [`CC_VERTEX_BITS-1:0] comp_low;
	} edge_payload;

	typedef struct packed {
		logic        valid;
		edge_payload payload;
	} edge_record;

endpackage

`default_nettype wire

/* source/sync_fifo.sv */
// push while full and pop while empty are dropped; almost full level comes from the defines header
`timescale 1ns/1ps
`default_nettype none

`include "cc_update_defs.svh"

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	output logic             full,
	output logic             alfull,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             valid,
	output logic             empty
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign full    = (count == CNT_BITS'(DEPTH));
	assign alfull  = (count >= CNT_BITS'(`CC_WRITE_FIFO_ALFULL));
	assign empty   = (count == '0);

	// pointers and occupancy
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			valid  <= 1'b0;
		end else begin
			valid <= do_pop;
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage and registered read port
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
		if (do_pop) begin
			data_out <= mem[rd_ptr];
		end
	end

endmodule

`default_nettype wire

/* source/update_kernel_control.sv */
// edge source must honour edge_request; out_degree of zero is not supported and closes the vertex every cycle
`timescale 1ns/1ps
`default_nettype none

`include "cc_update_defs.svh"

module update_kernel_control (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled_in,
	input  bus_pkg::cu_identity         identity,
	input  graph_pkg::vertex_job        vertex_job,
	input  graph_pkg::edge_record       edge_in,
	input  bus_pkg::buffer_status       data_status,
	input  bus_pkg::buffer_status       write_status,
	input  bus_pkg::write_response      write_resp,
	input  logic [`CC_EDGE_BITS-1:0]    continue_accum,
	output logic                        edge_request,
	output logic                        bus_request,
	input  logic                        bus_grant,
	output bus_pkg::write_command       write_out,
	output logic [`CC_VERTEX_BITS-1:0]  finished_vertices,
	output logic [`CC_EDGE_BITS-1:0]    write_count,
	output logic [`CC_EDGE_BITS-1:0]    edge_progress
);

	logic                     rstn_int;
	logic                     enabled;
	bus_pkg::cu_identity      identity_latched;
	logic                     vertex_valid_latched;
	graph_pkg::vertex_payload vertex_latched;
	logic                     edge_valid_latched;
	graph_pkg::edge_payload   edge_latched;
	bus_pkg::buffer_status    data_status_latched;
	bus_pkg::buffer_status    write_status_latched;
	logic                     resp_valid_latched;
	logic [`CC_EDGE_BITS-1:0] continue_latched;

	logic                  edge_test;
	logic                  comp_equal;
	logic                  cmd_valid;
	bus_pkg::write_payload cmd;
	logic                  push_valid;
	bus_pkg::write_payload push_cmd;

	logic [`CC_EDGE_BITS-1:0] resp_count;
	logic [`CC_EDGE_BITS-1:0] skip_count;
	logic                     vertex_done;

	logic                  grant_latched;
	logic                  fifo_pop;
	bus_pkg::buffer_status fifo_status;
	bus_pkg::write_payload fifo_data;

	////////////////////////////////////////
	// reset, enable and input latches
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rstn_int <= 1'b0;
		end else begin
			rstn_int <= 1'b1;
		end
	end

	always_ff @(posedge clock or negedge rstn_int) begin
		if (!rstn_int) begin
			enabled                    <= 1'b0;
			identity_latched           <= '0;
			vertex_valid_latched       <= 1'b0;
			edge_valid_latched         <= 1'b0;
			data_status_latched        <= '0;
			data_status_latched.empty  <= 1'b1;
			write_status_latched       <= '0;
			write_status_latched.empty <= 1'b1;
			resp_valid_latched         <= 1'b0;
			continue_latched           <= '0;
		end else begin
			enabled <= enabled_in;
			if (enabled) begin
				identity_latched     <= identity;
				vertex_valid_latched <= vertex_job.valid;
				edge_valid_latched   <= edge_in.valid;
				data_status_latched  <= data_status;
				write_status_latched <= write_status;
				resp_valid_latched   <= write_resp.valid;
				continue_latched     <= continue_accum;
			end
		end
	end

	always_ff @(posedge clock) begin
		vertex_latched <= vertex_job.payload;
		edge_latched   <= edge_in.payload;
	end

	////////////////////////////////////////
	// component match test
	////////////////////////////////////////

	// write comp_low at comp_high only when comp_high still owns itself
	assign edge_test  = enabled && vertex_valid_latched && edge_valid_latched;
	assign comp_equal = (edge_latched.comp_high == edge_latched.comp_comp_high);

	always_ff @(posedge clock or negedge rstn_int) begin
		if (!rstn_int) begin
			cmd_valid  <= 1'b0;
			push_valid <= 1'b0;
		end else begin
			cmd_valid  <= edge_test && comp_equal;
			push_valid <= enabled && cmd_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (edge_test) begin
			cmd.opcode   <= comp_equal ? bus_pkg::cmd_write_component : bus_pkg::cmd_none;
			cmd.index    <= edge_latched.comp_high;
			cmd.identity <= identity_latched;
			cmd.data     <= edge_latched.comp_low;
		end
		push_cmd <= cmd;
	end

	////////////////////////////////////////
	// per-vertex progress
	////////////////////////////////////////

	assign vertex_done = vertex_valid_latched && (edge_progress == vertex_latched.out_degree);

	always_ff @(posedge clock or negedge rstn_int) begin
		if (!rstn_int) begin
			resp_count        <= '0;
			skip_count        <= '0;
			edge_progress     <= '0;
			write_count       <= '0;
			finished_vertices <= '0;
		end else if (enabled) begin
			if (resp_valid_latched) begin
				write_count <= write_count + 1'b1;
			end
			if (vertex_done) begin
				finished_vertices <= finished_vertices + 1'b1;
				edge_progress     <= '0;
				// events of this cycle already belong to the next vertex
				resp_count <= {{(`CC_EDGE_BITS-1){1'b0}}, resp_valid_latched};
				skip_count <= {{(`CC_EDGE_BITS-1){1'b0}}, edge_test && !comp_equal};
			end else begin
				edge_progress <= resp_count + skip_count + continue_latched;
				resp_count    <= resp_count + resp_valid_latched;
				skip_count    <= skip_count + (edge_test && !comp_equal);
			end
		end
	end

	////////////////////////////////////////
	// write queue and bus side
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn_int) begin
		if (!rstn_int) begin
			grant_latched <= 1'b0;
			bus_request   <= 1'b0;
			edge_request  <= 1'b0;
		end else if (enabled) begin
			grant_latched <= bus_grant && !write_status_latched.alfull;
			bus_request   <= !fifo_status.empty && !write_status_latched.alfull;
			edge_request  <= !data_status_latched.empty && !fifo_status.alfull;
		end else begin
			grant_latched <= 1'b0;
			bus_request   <= 1'b0;
			edge_request  <= 1'b0;
		end
	end

	// recheck back-pressure on the cycle the pop happens
	assign fifo_pop = grant_latched && !write_status_latched.alfull;

	sync_fifo #(
		.WIDTH($bits(bus_pkg::write_payload)),
		.DEPTH(`CC_WRITE_FIFO_DEPTH)
	) write_fifo_i (
		.clock   (clock),
		.rstn    (rstn_int),
		.push    (push_valid),
		.data_in (push_cmd),
		.full    (fifo_status.full),
		.alfull  (fifo_status.alfull),
		.pop     (fifo_pop),
		.data_out(fifo_data),
		.valid   (fifo_status.valid),
		.empty   (fifo_status.empty)
	);

	// fifo read port is already registered, two cycles after the grant
	assign write_out = '{valid: fifo_status.valid, payload: fifo_data};

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
// free-running 100 ns clock; rstn is released on the tenth rising edge and never asserted again
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	initial begin
		rstn = 1'b0;
		repeat (10) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

`default_nettype wire

/* tests/update_tb.sv */
// single vertex job per run; grants are issued one at a time and the edge source obeys edge_request
`timescale 1ns/1ps
`default_nettype none

`include "cc_update_defs.svh"

module update_tb;

	localparam int RECORDS        = 40;
	localparam int FILL_CYCLES    = 60;
	localparam int TIMEOUT_CYCLES = 40 + RECORDS * 40 + FILL_CYCLES * 10 + 1500;
	localparam logic [15:0] UNIT_ID = 16'ha53c;

	logic clock;
	logic rstn;
	logic cfg_write;
	logic cfg_addr;
	logic [2*`CC_ID_BITS-1:0] cfg_data;
	graph_pkg::vertex_job vertex_job;
	graph_pkg::edge_record edge_in;
	bus_pkg::buffer_status data_status;
	bus_pkg::buffer_status write_status;
	bus_pkg::write_response write_resp;
	logic [`CC_EDGE_BITS-1:0] continue_accum;
	logic bus_grant;
	logic edge_request;
	logic bus_request;
	bus_pkg::write_command write_out;
	logic [`CC_VERTEX_BITS-1:0] finished_vertices;
	logic [`CC_EDGE_BITS-1:0] write_count;
	logic [`CC_EDGE_BITS-1:0] edge_progress;

	integer seed = 32'h983c37e2;
	bus_pkg::write_payload expected_q[$];
	bus_pkg::write_payload expected;
	int skips = 0;
	int resps_sent = 0;
	logic host_enabled = 1'b0;
	logic grants_on = 1'b0;

	tb_clock_gen clock_i (.clock(clock), .rstn(rstn));

	cu_update_top dut_i (
		.clock(clock), .rstn(rstn), .cfg_write(cfg_write), .cfg_addr(cfg_addr),
		.cfg_data(cfg_data), .vertex_job(vertex_job), .edge_in(edge_in),
		.edge_request(edge_request), .data_status(data_status),
		.write_status(write_status), .write_resp(write_resp),
		.continue_accum(continue_accum), .bus_request(bus_request), .bus_grant(bus_grant),
		.write_out(write_out), .finished_vertices(finished_vertices),
		.write_count(write_count), .edge_progress(edge_progress)
	);

	task automatic value_error(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		$display("ERR %s expected %h actual %h", name, exp, act);
		$display("SIMULATION FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic plain_error(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "stopping at first error");
	endtask

	////////////////////////////////////////
	// timing and back-pressure checks
	////////////////////////////////////////

	idle_check: assert property (@(posedge clock) disable iff (!rstn)
		!host_enabled |-> (!bus_request && !edge_request && !write_out.valid &&
			finished_vertices == 0 && write_count == 0 && edge_progress == 0))
		else plain_error("an output moved before the unit was enabled");

	empty_check: assert property (@(posedge clock) disable iff (!rstn)
		$past(data_status.empty, 2) |-> !edge_request)
		else plain_error("edge_request high while the edge buffer was empty");

	bp_request_check: assert property (@(posedge clock) disable iff (!rstn)
		$past(write_status.alfull, 2) |-> !bus_request)
		else plain_error("bus_request high under back-pressure");

	bp_write_check: assert property (@(posedge clock) disable iff (!rstn)
		$past(write_status.alfull, 2) |-> !write_out.valid)
		else plain_error("write_out.valid under back-pressure");

	// two-cycle grant to write latency
	grant_check: assert property (@(posedge clock) disable iff (!rstn)
		(host_enabled && bus_grant && !write_status.alfull && !$past(write_status.alfull))
			|-> ##2 write_out.valid)
		else plain_error("no write_out two cycles after a grant");

	// reference compare and write responses
	always @(posedge clock) begin
		write_resp.valid <= 1'b0;
		if (rstn && write_out.valid) begin
			if (expected_q.size() == 0) begin
				plain_error("write_out appeared with no matching record outstanding");
			end else begin
				expected = expected_q.pop_front();
				assert (write_out.payload == expected)
					else value_error("write payload", expected, write_out.payload);
				write_resp <= '{valid: 1'b1, identity: write_out.payload.identity};
				resps_sent++;
			end
		end
	end

	// one grant at a time, then wait for the request to settle
	always @(posedge clock) begin
		if (grants_on && bus_request) begin
			bus_grant <= 1'b1;
			@(posedge clock);
			bus_grant <= 1'b0;
			repeat (3) @(posedge clock);
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		$display("run timed out waiting for the DUT");
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

	// one random record, about half matching, with its predicted write
	task automatic make_record(output graph_pkg::edge_record rec);
		rec.valid = 1'b1;
		rec.payload.comp_high = $random(seed) & 32'hffff;
		rec.payload.comp_low = $random(seed);
		if ($random(seed) & 1) begin
			rec.payload.comp_comp_high = rec.payload.comp_high;
			expected_q.push_back('{opcode: bus_pkg::cmd_write_component,
				index: rec.payload.comp_high, identity: UNIT_ID,
				data: rec.payload.comp_low});
		end else begin
			rec.payload.comp_comp_high = rec.payload.comp_high ^ (($random(seed) & 32'hff) | 1);
			skips++;
		end
	endtask

	task automatic send_records(input int count);
		graph_pkg::edge_record rec;
		int sent;
		int cycles;
		sent = 0;
		cycles = 0;
		while (sent < count) begin
			@(posedge clock);
			cycles++;
			if (cycles > count * 30)
				plain_error("edge_request never allowed all records through");
			if (edge_request) begin
				make_record(rec);
				edge_in <= rec;
				sent++;
			end else begin
				edge_in.valid <= 1'b0;
			end
		end
		@(posedge clock);
		edge_in.valid <= 1'b0;
	endtask

	// keep offering records for a fixed window, taking only what edge_request allows
	task automatic offer_records(input int window);
		graph_pkg::edge_record rec;
		repeat (window) begin
			@(posedge clock);
			if (edge_request) begin
				make_record(rec);
				edge_in <= rec;
			end else begin
				edge_in.valid <= 1'b0;
			end
		end
		@(posedge clock);
		edge_in.valid <= 1'b0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (expected_q.size() != 0) begin
			@(posedge clock);
			cycles++;
			if (cycles > 1000)
				plain_error("queued writes never left the unit");
		end
		repeat (8) @(posedge clock);
	endtask

	initial begin
		int cycles;
		cfg_write = 1'b0;
		cfg_addr = 1'b0;
		cfg_data = '0;
		vertex_job = '0;
		edge_in = '0;
		data_status = '{full: 1'b0, alfull: 1'b0, empty: 1'b0, valid: 1'b1};
		write_status = '{full: 1'b0, alfull: 1'b0, empty: 1'b1, valid: 1'b0};
		write_resp = '0;
		continue_accum = '0;
		bus_grant = 1'b0;
		wait (rstn);
		@(posedge clock);

		// inputs toggling while disabled
		repeat (20) begin
			@(posedge clock);
			vertex_job <= '{valid: 1'b1, payload: '{id: 32'd3, out_degree: 32'd1}};
			edge_in <= '{valid: 1'b1, payload: '{comp_high: $random(seed),
				comp_comp_high: 32'd0, comp_low: $random(seed)}};
			bus_grant <= ~bus_grant;
		end
		@(posedge clock);
		edge_in.valid <= 1'b0;
		vertex_job.valid <= 1'b0;
		bus_grant <= 1'b0;
		repeat (4) @(posedge clock);

		////////////////////////////////////////
		// host setup and normal traffic
		////////////////////////////////////////
		cfg_write <= 1'b1;
		cfg_addr <= 1'b1;
		cfg_data <= UNIT_ID;
		@(posedge clock);
		cfg_addr <= 1'b0;
		cfg_data <= 16'd1;
		host_enabled <= 1'b1;
		@(posedge clock);
		cfg_write <= 1'b0;
		repeat (5) @(posedge clock);
		vertex_job <= '{valid: 1'b1, payload: '{id: 32'd7, out_degree: 32'hffff_ffff}};
		grants_on <= 1'b1;
		repeat (3) @(posedge clock);
		send_records(RECORDS);
		wait_drain();

		// edge buffer runs dry for a while
		data_status.empty <= 1'b1;
		repeat (6) @(posedge clock);
		data_status.empty <= 1'b0;

		// back-pressure from the write buffer
		grants_on <= 1'b0;
		repeat (8) @(posedge clock);
		write_status.alfull <= 1'b1;
		repeat (3) @(posedge clock);
		offer_records(FILL_CYCLES);
		repeat (6) @(posedge clock);
		// nothing leaves, so every accepted match is still queued
		assert (expected_q.size() >= `CC_WRITE_FIFO_ALFULL)
			else plain_error("edge_request dropped before the write queue was almost full");
		assert (expected_q.size() <= `CC_WRITE_FIFO_DEPTH)
			else plain_error("edge_request kept accepting records into a full write queue");
		repeat (4) begin
			bus_grant <= 1'b1;
			@(posedge clock);
			bus_grant <= 1'b0;
			@(posedge clock);
		end
		repeat (4) @(posedge clock);
		write_status.alfull <= 1'b0;
		grants_on <= 1'b1;
		wait_drain();

		////////////////////////////////////////
		// vertex completion
		////////////////////////////////////////
		repeat (10) @(posedge clock);
		assert (write_count == resps_sent)
			else value_error("write count", resps_sent, write_count);
		assert (edge_progress == skips + resps_sent)
			else value_error("edge progress", skips + resps_sent, edge_progress);
		@(posedge clock);
		continue_accum <= 32'd5;
		vertex_job.payload.out_degree <= skips + resps_sent + 5;
		cycles = 0;
		while (finished_vertices == 0) begin
			@(posedge clock);
			cycles++;
			if (cycles > 50)
				plain_error("vertex never finished after reaching out_degree");
		end
		vertex_job.valid <= 1'b0;
		continue_accum <= '0;
		repeat (6) @(posedge clock);
		assert (finished_vertices == 1)
			else value_error("finished vertices", 1, finished_vertices);
		assert (edge_progress == 0)
			else value_error("edge progress after finish", 0, edge_progress);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire
